// File: common/autotest_pkg.sv
//////////////////////////////////////////////////////////////////////
// widths, SD host request and reply structs, UUT clock rates,
// status codes and the sequencer state encoding
//////////////////////////////////////////////////////////////////////
package autotest_pkg;

  localparam int data_w = 32;

  // fixed card layout
  localparam logic [31:0] hdr_block = 32'd0;
  localparam logic [31:0] vec_block = 32'd1;
  localparam logic [31:0] res_block = 32'd2;

  // three little-endian operands per vector
  localparam int vec_bytes = 12;

  typedef struct packed {
    logic        rd_block;
    logic        wr_block;
    logic        rd_byte;
    logic        wr_byte;
    logic [31:0] block_addr;
    logic [7:0]  wdata;
  } sd_cmd_t;

  typedef struct packed {
    logic       busy;
    logic       err;
    logic [7:0] rdata;
  } sd_rsp_t;

  typedef enum logic [1:0] {full, half, quarter} clk_sel_t;

  typedef enum logic [2:0] {
    none, read_cmd_fail, write_cmd_fail, write_rejected, count_too_large
  } status_t;

  typedef enum logic [3:0] {
    s_idle, s_hdr_cmd, s_hdr_data, s_vec_cmd, s_vec_data,
    s_uut_run, s_wr_cmd, s_wr_data, s_done
  } fsm_state_t;

endpackage

// File: sd_host/sd_spi_host.sv
//////////////////////////////////////////////////////////////////////
// SD host in SPI mode, single-block CMD17 read and CMD24 write
// with byte-level data transfer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sd_spi_host
  import autotest_pkg::*;
#(
  parameter int sclk_div = 2
) (
  input  logic    clk,
  input  logic    reset,
  input  sd_cmd_t cmd,
  output sd_rsp_t rsp,
  output logic    cs,
  output logic    sclk,
  output logic    mosi,
  input  logic    miso
);

  typedef enum logic [3:0] {
    h_idle, h_cmd, h_r1, h_token, h_wr_tok, h_ready, h_data, h_crc, h_dresp, h_wbusy, h_end
  } host_state_t;

  host_state_t state;
  logic [47:0] frame;
  logic [2:0]  cnt;
  logic [8:0]  byte_cnt;
  logic        is_write;
  logic [7:0]  wbyte;
  logic        pend;
  logic        xfer_go;
  logic [7:0]  tx_byte;
  logic [7:0]  tx_next;

  logic [7:0]  tx_sr;
  logic [7:0]  rx_sr;
  logic [3:0]  hcnt;
  logic [7:0]  div_cnt;
  logic        shifting;
  logic        phase_end;
  logic        byte_done;

  // 16 half periods of sclk_div cycles per byte, mode 0
  assign phase_end = shifting && (div_cnt == 8'(sclk_div - 1));
  assign byte_done = phase_end && (hcnt == 4'd15);
  assign sclk      = hcnt[0];
  assign mosi      = tx_sr[7];

  always_ff @(posedge clk) begin
    if (reset) begin
      shifting <= 1'b0;
      hcnt     <= '0;
      div_cnt  <= '0;
      tx_sr    <= 8'hff;
    end else if (xfer_go) begin
      shifting <= 1'b1;
      div_cnt  <= '0;
      tx_sr    <= tx_byte;
    end else if (shifting) begin
      if (phase_end) begin
        div_cnt <= '0;
        hcnt    <= hcnt + 4'd1;
        // sample before the rising edge, shift out on the falling one
        if (hcnt[0])
          tx_sr <= {tx_sr[6:0], 1'b1};
        else
          rx_sr <= {rx_sr[6:0], miso};
        if (byte_done)
          shifting <= 1'b0;
      end else begin
        div_cnt <= div_cnt + 8'd1;
      end
    end
  end

  always_comb begin
    case (state)
      h_cmd:    tx_next = frame[47:40];
      h_wr_tok: tx_next = 8'hfe;
      h_data:   tx_next = is_write ? wbyte : 8'hff;
      default:  tx_next = 8'hff;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= h_idle;
      cs       <= 1'b1;
      rsp.busy <= 1'b0;
      rsp.err  <= 1'b0;
      pend     <= 1'b0;
      xfer_go  <= 1'b0;
    end else begin
      xfer_go <= 1'b0;
      // every state but idle and ready moves one byte at a time
      if (state != h_idle && state != h_ready && !pend) begin
        xfer_go <= 1'b1;
        pend    <= 1'b1;
        tx_byte <= tx_next;
      end
      if (byte_done)
        pend <= 1'b0;

      case (state)
        h_idle: begin
          if (cmd.rd_block || cmd.wr_block) begin
            rsp.busy <= 1'b1;
            rsp.err  <= 1'b0;
            cs       <= 1'b0;
            is_write <= cmd.wr_block;
            frame    <= {cmd.wr_block ? 8'h58 : 8'h51, cmd.block_addr, 8'hff};
            cnt      <= '0;
            byte_cnt <= '0;
            state    <= h_cmd;
          end
        end
        h_cmd: begin
          if (byte_done) begin
            frame <= {frame[39:0], 8'hff};
            cnt   <= cnt + 3'd1;
            if (cnt == 3'd5) begin
              cnt   <= '0;
              state <= h_r1;
            end
          end
        end
        h_r1: begin
          if (byte_done) begin
            cnt <= cnt + 3'd1;
            if (rx_sr != 8'hff) begin
              if (rx_sr != 8'h00) begin
                rsp.err <= 1'b1;
                state   <= h_end;
              end else begin
                state <= is_write ? h_wr_tok : h_token;
              end
            end else if (cnt == 3'd7) begin
              // no R1 within 8 bytes
              rsp.err <= 1'b1;
              state   <= h_end;
            end
          end
        end
        h_token: begin
          if (byte_done && rx_sr == 8'hfe) begin
            rsp.busy <= 1'b0;
            state    <= h_ready;
          end
        end
        h_wr_tok: begin
          if (byte_done) begin
            rsp.busy <= 1'b0;
            state    <= h_ready;
          end
        end
        h_ready: begin
          if ((cmd.rd_byte && !is_write) || (cmd.wr_byte && is_write)) begin
            rsp.busy <= 1'b1;
            wbyte    <= cmd.wdata;
            state    <= h_data;
          end
        end
        h_data: begin
          if (byte_done) begin
            if (!is_write)
              rsp.rdata <= rx_sr;
            byte_cnt <= byte_cnt + 9'd1;
            if (&byte_cnt) begin
              cnt   <= '0;
              state <= h_crc;
            end else begin
              rsp.busy <= 1'b0;
              state    <= h_ready;
            end
          end
        end
        h_crc: begin
          // two dummy CRC bytes in either direction
          if (byte_done) begin
            cnt <= cnt + 3'd1;
            if (cnt == 3'd1)
              state <= is_write ? h_dresp : h_end;
          end
        end
        h_dresp: begin
          if (byte_done) begin
            if (rx_sr[4:0] == 5'b00101) begin
              state <= h_wbusy;
            end else begin
              rsp.err <= 1'b1;
              state   <= h_end;
            end
          end
        end
        h_wbusy: begin
          if (byte_done && rx_sr != 8'h00)
            state <= h_end;
        end
        h_end: begin
          // one trailing byte with cs released
          cs <= 1'b1;
          if (byte_done) begin
            rsp.busy <= 1'b0;
            state    <= h_idle;
          end
        end
        default: state <= h_idle;
      endcase
    end
  end

endmodule

// File: autotest/autotest_fsm.sv
//////////////////////////////////////////////////////////////////////
// run sequencer: header parse, vector streaming into the UUT,
// result collection and write-back to the card
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module autotest_fsm
  import autotest_pkg::*;
#(
  parameter int  max_vectors = 40,
  localparam int aw          = $clog2(max_vectors)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  output sd_cmd_t           cmd,
  input  sd_rsp_t           rsp,
  output logic              uut_rst,
  input  logic              end_uut,
  input  logic              uut_ce,
  output clk_sel_t          clk_sel,
  output logic [data_w-1:0] op_a,
  output logic [data_w-1:0] op_b,
  output logic [data_w-1:0] op_c,
  input  logic [data_w-1:0] uut_result,
  output logic              buf_we,
  output logic [aw-1:0]     buf_addr,
  output logic [data_w-1:0] buf_wdata,
  input  logic [data_w-1:0] buf_rdata,
  input  logic [1:0]        sw_debug,
  output logic              done,
  output logic              err_flag,
  output logic [31:0]       debug
);

  fsm_state_t             state;
  status_t                status;
  logic [8:0]             byte_idx;
  logic [3:0]             vb;
  logic [7:0]             vec_idx;
  logic [7:0]             count;
  logic [8*vec_bytes-1:0] vec_sr;
  logic [data_w-1:0]      last_result;
  logic                   host_idle;
  logic                   last_byte;
  logic                   vec_full;
  logic                   writing;
  logic [7:0]             wr_val;

  // a pulse in flight counts as busy, the host raises busy a cycle later
  assign host_idle = !rsp.busy &&
                     !(cmd.rd_block || cmd.wr_block || cmd.rd_byte || cmd.wr_byte);
  assign last_byte = &byte_idx;
  assign vec_full  = (vb == 4'(vec_bytes - 1));
  assign writing   = (state == s_wr_cmd) || (state == s_wr_data);

  assign op_a = vec_sr[data_w-1:0];
  assign op_b = vec_sr[2*data_w-1:data_w];
  assign op_c = vec_sr[3*data_w-1:2*data_w];

  assign buf_we    = (state == s_uut_run) && end_uut && uut_ce;
  assign buf_wdata = uut_result;
  assign buf_addr  = writing ? aw'(byte_idx[8:2]) : aw'(vec_idx);

  // results go out little-endian, zero past the last vector
  assign wr_val = (byte_idx[8:2] < count) ? buf_rdata[8*byte_idx[1:0] +: 8] : 8'h00;

  always_comb begin
    case (sw_debug)
      2'd0:    debug = {25'd0, state, status};
      2'd1:    debug = {24'd0, vec_idx};
      2'd2:    debug = last_result;
      default: debug = {24'd0, count};
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= s_idle;
      status       <= none;
      cmd.rd_block <= 1'b0;
      cmd.wr_block <= 1'b0;
      cmd.rd_byte  <= 1'b0;
      cmd.wr_byte  <= 1'b0;
      uut_rst      <= 1'b1;
      done         <= 1'b0;
      err_flag     <= 1'b0;
      byte_idx     <= '0;
      vb           <= '0;
      vec_idx      <= '0;
      count        <= '0;
      clk_sel      <= full;
      last_result  <= '0;
    end else begin
      cmd.rd_block <= 1'b0;
      cmd.wr_block <= 1'b0;
      cmd.rd_byte  <= 1'b0;
      cmd.wr_byte  <= 1'b0;

      case (state)
        s_idle, s_done: begin
          if (start && host_idle) begin
            status         <= none;
            done           <= 1'b0;
            err_flag       <= 1'b0;
            byte_idx       <= '0;
            vb             <= '0;
            vec_idx        <= '0;
            cmd.rd_block   <= 1'b1;
            cmd.block_addr <= hdr_block;
            state          <= s_hdr_cmd;
          end
        end
        s_hdr_cmd, s_vec_cmd: begin
          if (host_idle) begin
            if (rsp.err) begin
              status   <= read_cmd_fail;
              done     <= 1'b1;
              err_flag <= 1'b1;
              state    <= s_done;
            end else begin
              cmd.rd_byte <= 1'b1;
              state       <= (state == s_hdr_cmd) ? s_hdr_data : s_vec_data;
            end
          end
        end
        s_hdr_data: begin
          if (host_idle) begin
            byte_idx <= byte_idx + 9'd1;
            if (byte_idx == 9'd0)
              count <= rsp.rdata;
            if (byte_idx == 9'd1)
              clk_sel <= clk_sel_t'(rsp.rdata[1:0]);
            if (!last_byte) begin
              cmd.rd_byte <= 1'b1;
            end else if (count > max_vectors) begin
              status   <= count_too_large;
              done     <= 1'b1;
              err_flag <= 1'b1;
              state    <= s_done;
            end else begin
              cmd.rd_block   <= 1'b1;
              cmd.block_addr <= vec_block;
              state          <= s_vec_cmd;
            end
          end
        end
        s_vec_data: begin
          if (host_idle) begin
            vec_sr   <= {rsp.rdata, vec_sr[8*vec_bytes-1:8]};
            byte_idx <= byte_idx + 9'd1;
            vb       <= vec_full ? 4'd0 : vb + 4'd1;
            if (vec_full && vec_idx < count) begin
              // operands settle in the same edge that releases the UUT
              uut_rst <= 1'b0;
              state   <= s_uut_run;
            end else if (last_byte) begin
              cmd.wr_block   <= 1'b1;
              cmd.block_addr <= res_block;
              state          <= s_wr_cmd;
            end else begin
              cmd.rd_byte <= 1'b1;
            end
          end
        end
        s_uut_run: begin
          if (end_uut && uut_ce) begin
            last_result <= uut_result;
            uut_rst     <= 1'b1;
            vec_idx     <= vec_idx + 8'd1;
            cmd.rd_byte <= 1'b1;
            state       <= s_vec_data;
          end
        end
        s_wr_cmd, s_wr_data: begin
          if (host_idle) begin
            if (rsp.err || (state == s_wr_data && byte_idx == 9'd0)) begin
              // all 512 bytes sent, or the card refused
              if (rsp.err)
                status <= (state == s_wr_cmd) ? write_cmd_fail : write_rejected;
              done     <= 1'b1;
              err_flag <= rsp.err;
              state    <= s_done;
            end else begin
              cmd.wr_byte <= 1'b1;
              cmd.wdata   <= wr_val;
              byte_idx    <= byte_idx + 9'd1;
              state       <= s_wr_data;
            end
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

// File: logic/uut_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// UUT clock enable at full, half or quarter rate
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uut_clock_gen
  import autotest_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  clk_sel_t clk_sel,
  output logic     uut_ce
);

  logic [1:0] div_cnt;

  always_ff @(posedge clk) begin
    if (reset)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 2'd1;
  end

  // an unused select code runs at the slowest rate
  always_comb begin
    case (clk_sel)
      full:    uut_ce = 1'b1;
      half:    uut_ce = div_cnt[0];
      default: uut_ce = &div_cnt;
    endcase
  end

endmodule

// File: logic/result_buffer.sv
//////////////////////////////////////////////////////////////////////
// single-port result RAM with registered read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module result_buffer
  import autotest_pkg::*;
#(
  parameter int  max_vectors = 40,
  localparam int aw          = $clog2(max_vectors)
) (
  input  logic              clk,
  input  logic              we,
  input  logic [aw-1:0]     addr,
  input  logic [data_w-1:0] wdata,
  output logic [data_w-1:0] rdata
);

  logic [data_w-1:0] mem [max_vectors];

  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];
  end

endmodule

// File: logic/uut_mac.sv
//////////////////////////////////////////////////////////////////////
// example UUT, staged a * b + c over four enabled cycles
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uut_mac
  import autotest_pkg::*;
(
  input  logic              clk,
  input  logic              uut_rst,
  input  logic              uut_ce,
  input  logic [data_w-1:0] op_a,
  input  logic [data_w-1:0] op_b,
  input  logic [data_w-1:0] op_c,
  output logic [data_w-1:0] result,
  output logic              end_uut
);

  localparam int hw = data_w / 2;

  logic [2:0]        step;
  logic [data_w-1:0] pp_lo;
  logic [hw-1:0]     pp_cross;

  // step 4 parks the pipeline until the next reset
  always_ff @(posedge clk) begin
    if (uut_rst)
      step <= '0;
    else if (uut_ce && step != 3'd4)
      step <= step + 3'd1;
  end

  always_ff @(posedge clk) begin
    if (uut_ce) begin
      case (step)
        3'd0: pp_lo <= op_a[hw-1:0] * op_b[hw-1:0];
        // only the low half of the cross terms reaches a 32-bit result
        3'd1: pp_cross <= op_a[hw-1:0] * op_b[data_w-1:hw] + op_a[data_w-1:hw] * op_b[hw-1:0];
        3'd2: result <= pp_lo + {pp_cross, {hw{1'b0}}} + op_c;
        default: ;
      endcase
    end
  end

  assign end_uut = uut_ce && (step == 3'd3);

endmodule

// File: logic/autotest_top.sv
//////////////////////////////////////////////////////////////////////
// self-test harness top with SD host, sequencer, UUT clock enable,
// result buffer and the example multiply-add UUT
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module autotest_top
  import autotest_pkg::*;
#(
  parameter int  max_vectors = 40,
  parameter int  sclk_div    = 2,
  localparam int aw          = $clog2(max_vectors)
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  output logic        cs,
  output logic        sclk,
  output logic        mosi,
  input  logic        miso,
  input  logic [1:0]  sw_debug,
  output logic        done,
  output logic        err_flag,
  output logic [31:0] debug
);

  sd_cmd_t           sd_cmd;
  sd_rsp_t           sd_rsp;
  clk_sel_t          clk_sel;
  logic              uut_ce;
  logic              uut_rst;
  logic              end_uut;
  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] op_c;
  logic [data_w-1:0] uut_result;
  logic              buf_we;
  logic [aw-1:0]     buf_addr;
  logic [data_w-1:0] buf_wdata;
  logic [data_w-1:0] buf_rdata;

  autotest_fsm #(
    .max_vectors(max_vectors)
  ) u_fsm (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .cmd       (sd_cmd),
    .rsp       (sd_rsp),
    .uut_rst   (uut_rst),
    .end_uut   (end_uut),
    .uut_ce    (uut_ce),
    .clk_sel   (clk_sel),
    .op_a      (op_a),
    .op_b      (op_b),
    .op_c      (op_c),
    .uut_result(uut_result),
    .buf_we    (buf_we),
    .buf_addr  (buf_addr),
    .buf_wdata (buf_wdata),
    .buf_rdata (buf_rdata),
    .sw_debug  (sw_debug),
    .done      (done),
    .err_flag  (err_flag),
    .debug     (debug)
  );

  sd_spi_host #(
    .sclk_div(sclk_div)
  ) u_sd_host (
    .clk  (clk),
    .reset(reset),
    .cmd  (sd_cmd),
    .rsp  (sd_rsp),
    .cs   (cs),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  uut_clock_gen u_clock_gen (
    .clk    (clk),
    .reset  (reset),
    .clk_sel(clk_sel),
    .uut_ce (uut_ce)
  );

  result_buffer #(
    .max_vectors(max_vectors)
  ) u_result_buffer (
    .clk  (clk),
    .we   (buf_we),
    .addr (buf_addr),
    .wdata(buf_wdata),
    .rdata(buf_rdata)
  );

  uut_mac u_uut (
    .clk    (clk),
    .uut_rst(uut_rst),
    .uut_ce (uut_ce),
    .op_a   (op_a),
    .op_b   (op_b),
    .op_c   (op_c),
    .result (uut_result),
    .end_uut(end_uut)
  );

endmodule

// File: verif/sd_card_model.sv
//////////////////////////////////////////////////////////////////////
// behavioral SD card in SPI mode, CMD17/CMD24 parser, block memory
// and R1 / write-token error injection
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sd_card_model (
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  input  logic inject_r1,
  input  logic inject_reject
);

  typedef enum {m_cmd, m_idle, m_wtok, m_wdata, m_wcrc} card_mode_t;

  // blocks 0 to 3, byte addressed
  logic [7:0] mem [0:2047];

  card_mode_t mode;
  logic [7:0] rx;
  logic [7:0] tx_sr;
  logic [7:0] cmd_buf [6];
  logic [7:0] wbuf [512];
  logic [7:0] out_q [$];
  int         bit_cnt;
  int         cmd_cnt;
  int         data_cnt;
  int         base;

  assign miso = cs ? 1'b1 : tx_sr[7];

  task automatic take_byte(input logic [7:0] b);
    logic [7:0] r1;
    case (mode)
      m_cmd: begin
        // a frame starts with the 01 prefix, idle 0xff bytes are skipped
        if (cmd_cnt > 0 || b[7:6] == 2'b01) begin
          cmd_buf[cmd_cnt] = b;
          cmd_cnt++;
          if (cmd_cnt == 6) begin
            cmd_cnt = 0;
            base = int'({cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]} & 32'd3) * 512;
            r1 = inject_r1 ? 8'h04 : 8'h00;
            out_q.push_back(8'hff);
            out_q.push_back(r1);
            mode = m_idle;
            if (r1 == 8'h00 && cmd_buf[0] == 8'h51) begin
              out_q.push_back(8'hff);
              out_q.push_back(8'hfe);
              for (int i = 0; i < 512; i++)
                out_q.push_back(mem[base + i]);
              out_q.push_back(8'hff);
              out_q.push_back(8'hff);
            end else if (r1 == 8'h00 && cmd_buf[0] == 8'h58) begin
              mode = m_wtok;
            end
          end
        end
      end
      m_wtok: begin
        if (b == 8'hfe) begin
          data_cnt = 0;
          mode = m_wdata;
        end
      end
      m_wdata: begin
        wbuf[data_cnt] = b;
        data_cnt++;
        if (data_cnt == 512) begin
          data_cnt = 0;
          mode = m_wcrc;
        end
      end
      m_wcrc: begin
        data_cnt++;
        if (data_cnt == 2) begin
          if (inject_reject) begin
            out_q.push_back(8'h0b);
          end else begin
            // accepted token, then two busy bytes
            out_q.push_back(8'h05);
            out_q.push_back(8'h00);
            out_q.push_back(8'h00);
            for (int i = 0; i < 512; i++)
              mem[base + i] = wbuf[i];
          end
          mode = m_idle;
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    mode    = m_cmd;
    bit_cnt = 0;
    cmd_cnt = 0;
    tx_sr   = 8'hff;
  end

  // deselect ends any transaction
  always @(posedge cs) begin
    mode    = m_cmd;
    bit_cnt = 0;
    cmd_cnt = 0;
    tx_sr   = 8'hff;
    out_q.delete();
  end

  always @(posedge sclk) begin
    if (!cs) begin
      rx = {rx[6:0], mosi};
      bit_cnt++;
    end
  end

  always @(negedge sclk) begin
    if (!cs) begin
      if (bit_cnt == 8) begin
        bit_cnt = 0;
        take_byte(rx);
        tx_sr = (out_q.size() > 0) ? out_q.pop_front() : 8'hff;
      end else begin
        tx_sr = {tx_sr[6:0], 1'b1};
      end
    end
  end

endmodule

// File: verif/autotest_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the self-test harness with an SD card model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module autotest_tb;

  localparam int     max_vectors = 40;
  localparam int     sclk_div    = 2;
  localparam int     n_runs      = 5;
  localparam longint watch_ns    = longint'(n_runs) * 3 * 530 * 16 * sclk_div * 10 * 2;
  // status codes in debug[2:0]
  localparam logic [2:0] st_read_cmd_fail   = 3'd1;
  localparam logic [2:0] st_write_rejected  = 3'd3;
  localparam logic [2:0] st_count_too_large = 3'd4;

  logic        clk;
  logic        reset;
  logic        start;
  logic [1:0]  sw_debug;
  logic        inject_r1;
  logic        inject_reject;
  logic        cs;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic        done;
  logic        err_flag;
  logic [31:0] debug;

  logic [31:0] file_words [0:23];
  logic [31:0] va [max_vectors];
  logic [31:0] vb [max_vectors];
  logic [31:0] vc [max_vectors];
  int          errors;
  int          checks;
  int          test_start_errors;
  int          seed;

  autotest_top #(
    .max_vectors(max_vectors),
    .sclk_div   (sclk_div)
  ) uut (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .cs      (cs),
    .sclk    (sclk),
    .mosi    (mosi),
    .miso    (miso),
    .sw_debug(sw_debug),
    .done    (done),
    .err_flag(err_flag),
    .debug   (debug)
  );

  sd_card_model card (
    .cs           (cs),
    .sclk         (sclk),
    .mosi         (mosi),
    .miso         (miso),
    .inject_r1    (inject_r1),
    .inject_reject(inject_reject)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watch_ns);
    $display("watchdog expired before the tests completed");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr) ^ 8'(addr >> 8) ^ 8'h5a;
  endfunction

  function automatic logic [31:0] result_word(input int i);
    int a;
    a = 1024 + 4 * i;
    return {card.mem[a + 3], card.mem[a + 2], card.mem[a + 1], card.mem[a]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("error: %s", what);
      errors++;
    end
  endtask

  // header, vectors, and a fill pattern in the result block
  task automatic load_card(input int count, input int clk_sel, input int n);
    for (int i = 0; i < 2048; i++)
      card.mem[i] = fill_byte(i);
    for (int i = 0; i < 1024; i++)
      card.mem[i] = 8'h00;
    card.mem[0] = 8'(count);
    card.mem[1] = 8'(clk_sel);
    for (int v = 0; v < n; v++) begin
      for (int k = 0; k < 4; k++) begin
        card.mem[512 + 12 * v + k]     = va[v][8 * k +: 8];
        card.mem[512 + 12 * v + 4 + k] = vb[v][8 * k +: 8];
        card.mem[512 + 12 * v + 8 + k] = vc[v][8 * k +: 8];
      end
    end
  endtask

  task automatic run_harness();
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
    end
  endtask

  // debug is combinational, so it settles right after the select
  task automatic show_debug(input logic [1:0] sel);
    @(posedge clk);
    #1 sw_debug = sel;
    #1;
  endtask

  task automatic check_results(input int n);
    logic [31:0] exp;
    check_true(done && !err_flag, "run ended with err_flag high");
    for (int i = 0; i < n; i++) begin
      exp = va[i] * vb[i] + vc[i];
      check_val($sformatf("result[%0d]", i), result_word(i), exp);
    end
    for (int i = n; i < 128; i++)
      check_val($sformatf("pad word[%0d]", i), result_word(i), 32'h0);
  endtask

  task automatic check_untouched();
    int bad;
    bad = 0;
    for (int i = 1024; i < 1536; i++)
      if (card.mem[i] !== fill_byte(i))
        bad++;
    check_true(bad == 0, "result block was written during a failed run");
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %s", num, name,
             (errors == test_start_errors) ? "ok" : "errors");
    test_start_errors = errors;
  endtask

  task automatic load_file_vectors();
    for (int i = 0; i < 5; i++) begin
      va[i] = file_words[4 + 4 * i];
      vb[i] = file_words[5 + 4 * i];
      vc[i] = file_words[6 + 4 * i];
    end
  endtask

  initial begin
    reset         = 1'b1;
    start         = 1'b0;
    sw_debug      = 2'd0;
    inject_r1     = 1'b0;
    inject_reject = 1'b0;
    errors        = 0;
    checks        = 0;
    seed          = 19;
    test_start_errors = 0;
    $readmemh("verif/autotest_vectors.txt", file_words);
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;

    // file vectors checked against the expected words in the file too
    load_file_vectors();
    load_card(file_words[0], file_words[1], 5);
    run_harness();
    check_results(5);
    for (int i = 0; i < 5; i++)
      check_val($sformatf("file result[%0d]", i), result_word(i), file_words[7 + 4 * i]);
    finish_test(1, "full rate file vectors");

    for (int i = 0; i < max_vectors; i++) begin
      va[i] = $random(seed);
      vb[i] = $random(seed);
      vc[i] = $random(seed);
    end
    load_card(max_vectors, 2, max_vectors);
    run_harness();
    check_results(max_vectors);
    finish_test(2, "quarter rate random vectors");

    show_debug(2'd3);
    check_val("debug", debug, 32'(max_vectors));
    // vector index and last result after the same run
    show_debug(2'd1);
    check_val("debug", debug, 32'(max_vectors));
    show_debug(2'd2);
    check_val("debug", debug,
              va[max_vectors - 1] * vb[max_vectors - 1] + vc[max_vectors - 1]);
    show_debug(2'd0);
    finish_test(6, "debug shows count");

    load_file_vectors();
    load_card(5, 0, 5);
    @(posedge clk);
    #1 inject_r1 = 1'b1;
    run_harness();
    check_true(err_flag, "err_flag low after a failed header read");
    check_val("status", {29'd0, debug[2:0]}, {29'd0, st_read_cmd_fail});
    check_untouched();
    inject_r1 = 1'b0;
    finish_test(3, "header read R1 error");

    load_card(5, 0, 5);
    inject_reject = 1'b1;
    run_harness();
    check_true(err_flag, "err_flag low after a rejected write");
    check_val("status", {29'd0, debug[2:0]}, {29'd0, st_write_rejected});
    inject_reject = 1'b0;
    finish_test(4, "write token rejected");

    load_card(max_vectors + 1, 0, 5);
    run_harness();
    check_true(err_flag, "err_flag low after an oversized count");
    check_val("status", {29'd0, debug[2:0]}, {29'd0, st_count_too_large});
    check_untouched();
    finish_test(5, "count too large");

    $display("checks: %0d, failed: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verif/autotest_vectors.txt
// row 0: vector count, clk_sel, unused, unused
// rows 1 to 5: a, b, c, expected a*b+c mod 2^32 (hex words)
00000005 00000000 00000000 00000000
// small operands
00000003 00000005 00000007 00000016
// product wraps to zero before c
00010000 00010000 00000001 00000001
// all ones times two
ffffffff 00000002 00000000 fffffffe
// high bits lost in the shift
12345678 00000010 00000008 23456788
// large addend
00001000 00000100 abcd0000 abdd0000

// File: vlog.f
common/autotest_pkg.sv
sd_host/sd_spi_host.sv
autotest/autotest_fsm.sv
logic/uut_clock_gen.sv
logic/result_buffer.sv
logic/uut_mac.sv
logic/autotest_top.sv
verif/sd_card_model.sv
verif/autotest_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the harness testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module autotest_tb -o autotest_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/autotest_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
